/* decoder.f */
+incdir+rtl
rtl/decoderPkg.sv
rtl/ctrlBus.sv
rtl/condEval.sv
rtl/controlGen.sv
rtl/instrRewrite.sv
rtl/decodeStage.sv
rtl/decoderTop.sv
sim/decoderTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the decoder testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module decoderTb -f decoder.f -o decoderSim \
    > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/decoderSim > sim.log 2>&1 || echo "simulator returned an error status"

grep -qx "NO ERRORS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* sim/decoderTb.sv */
// decoder testbench checking directed and random instructions against a reference decode
`timescale 1ns/100ps
`default_nettype none

module decoderTb;

    localparam logic [15:0] nopWord = 16'h0020;

    // one expected output set per strobe
    typedef struct packed {
        logic        regWriteEn;
        logic        ramWriteEn;
        logic        pcWrite;
        logic        immSelect;
        logic [1:0]  immType;
        logic        pcOrRegSelect;
        logic        aluWriteBack;
        logic [3:0]  regWriteAddr;
        logic [3:0]  linkReg;
        logic [15:0] word;
    } expected_t;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [15:0] instruction;
    logic [4:0]  psr;
    logic        outValid;
    logic        regWriteEn;
    logic        ramWriteEn;
    logic        pcWrite;
    logic        immSelect;
    logic [1:0]  immType;
    logic        pcOrRegSelect;
    logic        aluWriteBack;
    logic [3:0]  regWriteAddr;
    logic [3:0]  linkReg;
    logic [15:0] instructionOut;

    integer      seed;
    logic [31:0] rnd;
    int          errorCount;
    int          sentCount;
    int          checkCount;
    int          guard;

    decoderTop u_dut (
        .clk            (clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .instruction    (instruction),
        .psr            (psr),
        .outValid       (outValid),
        .regWriteEn     (regWriteEn),
        .ramWriteEn     (ramWriteEn),
        .pcWrite        (pcWrite),
        .immSelect      (immSelect),
        .immType        (immType),
        .pcOrRegSelect  (pcOrRegSelect),
        .aluWriteBack   (aluWriteBack),
        .regWriteAddr   (regWriteAddr),
        .linkReg        (linkReg),
        .instructionOut (instructionOut)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // flags are n z f l c from bit 4 down
    function automatic logic condTaken(input logic [3:0] code, input logic [4:0] f);
        case (code)
            4'h0: return f[3];
            4'h1: return !f[3];
            4'h2: return f[0];
            4'h3: return !f[0];
            4'h4: return f[1];
            4'h5: return !f[1];
            4'h6: return f[4];
            4'h7: return !f[4];
            4'h8: return f[2];
            4'h9: return !f[2];
            4'hA: return !f[1] && !f[3];
            4'hB: return f[1] || f[3];
            4'hC: return !f[4] && !f[3];
            4'hD: return f[4] || f[3];
            4'hE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // immType codes are 0 raw, 1 sign, 2 zero, 3 none
    function automatic expected_t refDecode(input logic [15:0] w, input logic [4:0] f);
        expected_t e;
        logic [3:0] op;
        logic [3:0] rd;
        logic [3:0] ext;
        logic [3:0] rs;
        logic       tk;
        op = w[15:12];
        rd = w[11:8];
        ext = w[7:4];
        rs = w[3:0];
        tk = condTaken(rd, f);
        e = '0;
        e.pcOrRegSelect = 1'b1;
        e.aluWriteBack = 1'b1;
        e.regWriteAddr = rd;
        e.word = w;
        case (op)
            4'h0: e.regWriteEn = (ext != 4'hB);
            4'h8: begin
                e.regWriteEn = 1'b1;
                e.immSelect = (ext != 4'h4);
            end
            4'h5, 4'h6, 4'h9: begin
                e.regWriteEn = 1'b1;
                e.immSelect = 1'b1;
                e.immType = 2'd1;
            end
            4'hB: begin
                e.immSelect = 1'b1;
                e.immType = 2'd1;
            end
            4'h1, 4'h2, 4'h3, 4'hD: begin
                e.regWriteEn = 1'b1;
                e.immSelect = 1'b1;
                e.immType = 2'd2;
            end
            4'hF: begin
                e.regWriteEn = 1'b1;
                e.immSelect = 1'b1;
            end
            4'h4: begin
                // load, store, jal, jcond by extension
                if (ext == 4'h0) begin
                    e.regWriteEn = 1'b1;
                    e.immSelect = 1'b1;
                    e.immType = 2'd3;
                    e.aluWriteBack = 1'b0;
                    e.word = {4'h0, rd, 4'h6, rs};
                end else if (ext == 4'h4) begin
                    e.ramWriteEn = 1'b1;
                    e.word = {4'h0, rs, 4'h6, rd};
                end else if (ext == 4'h8 || (ext == 4'hC && tk)) begin
                    e.pcWrite = 1'b1;
                    e.immSelect = 1'b1;
                    e.immType = 2'd3;
                    e.linkReg = (ext == 4'h8) ? rd : 4'h0;
                    e.word = {4'h0, 4'h0, 4'h6, rs};
                end else if (ext == 4'hC) begin
                    e.word = nopWord;
                end
            end
            4'hC: begin
                if (tk) begin
                    e.pcWrite = 1'b1;
                    e.immSelect = 1'b1;
                    e.immType = 2'd1;
                    e.pcOrRegSelect = 1'b0;
                    e.word = {8'h50, w[7:0]};
                end else begin
                    e.word = nopWord;
                end
            end
            default: e.word = w;
        endcase
        if (w == 16'h0000) begin
            e.word = nopWord;
        end
        return e;
    endfunction

    task automatic compareField(input string name, input logic [15:0] want,
                                input logic [15:0] got);
        if (got !== want) begin
            errorCount++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t", name, want, got, $time);
        end
    endtask

    task automatic sendInstr(input logic [15:0] w, input logic [4:0] f);
        @(negedge clk);
        instrValid = 1'b1;
        instruction = w;
        psr = f;
        sentCount++;
    endtask

    // garbage on the bus that must not be captured
    task automatic idleCycle();
        @(negedge clk);
        instrValid = 1'b0;
        rnd = $random(seed);
        instruction = rnd[15:0];
        psr = rnd[20:16];
    endtask

    // reference taken at the capturing edge and outputs checked half a cycle later
    initial begin : compareProc
        expected_t want;
        logic      strobeSeen;
        forever begin
            @(posedge clk);
            strobeSeen = rstN && instrValid;
            want = refDecode(instruction, psr);
            @(negedge clk);
            compareField("outValid", 16'(strobeSeen), 16'(outValid));
            if (strobeSeen) begin
                compareField("regWriteEn", 16'(want.regWriteEn), 16'(regWriteEn));
                compareField("ramWriteEn", 16'(want.ramWriteEn), 16'(ramWriteEn));
                compareField("pcWrite", 16'(want.pcWrite), 16'(pcWrite));
                compareField("immSelect", 16'(want.immSelect), 16'(immSelect));
                compareField("immType", 16'(want.immType), 16'(immType));
                compareField("pcOrRegSelect", 16'(want.pcOrRegSelect), 16'(pcOrRegSelect));
                compareField("aluWriteBack", 16'(want.aluWriteBack), 16'(aluWriteBack));
                compareField("regWriteAddr", 16'(want.regWriteAddr), 16'(regWriteAddr));
                compareField("linkReg", 16'(want.linkReg), 16'(linkReg));
                compareField("instructionOut", want.word, instructionOut);
                // only outputs the DUT marks valid count as delivered
                if (outValid === 1'b1) begin
                    checkCount++;
                end
            end else begin
                // enables drop on idle cycles
                compareField("regWriteEn", 16'h0, 16'(regWriteEn));
                compareField("ramWriteEn", 16'h0, 16'(ramWriteEn));
                compareField("pcWrite", 16'h0, 16'(pcWrite));
            end
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instruction = '0;
        psr = '0;
        seed = 92796;
        errorCount = 0;
        sentCount = 0;
        checkCount = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // nothing strobed yet
        @(negedge clk);
        compareField("instructionOut", 16'h0000, instructionOut);

        // register and immediate groups over all extensions
        for (int op = 0; op < 16; op++) begin
            if (op == 4 || op == 12) continue;
            for (int ext = 0; ext < 16; ext++) begin
                rnd = $random(seed);
                sendInstr({4'(op), 4'(op ^ ext), 4'(ext), rnd[3:0]}, rnd[8:4]);
            end
            idleCycle();
        end

        // load, store, jal and unused memory extensions
        for (int ext = 0; ext < 16; ext++) begin
            for (int r = 0; r < 4; r++) begin
                sendInstr({4'h4, 4'(r * 5 + ext), 4'(ext), 4'(15 - r * 3)}, 5'h00);
            end
            idleCycle();
        end

        // every condition against every flag value with jump then branch
        for (int c = 0; c < 16; c++) begin
            for (int f = 0; f < 32; f++) begin
                rnd = $random(seed);
                sendInstr({4'h4, 4'(c), 4'hC, rnd[3:0]}, 5'(f));
                sendInstr({4'hC, 4'(c), rnd[15:8]}, 5'(f));
            end
            idleCycle();
        end

        // all-zero word beside the real nop
        sendInstr(16'h0000, 5'h1F);
        idleCycle();
        sendInstr(nopWord, 5'h00);
        sendInstr(16'h0000, 5'h00);

        // back to back random traffic
        repeat (400) begin
            rnd = $random(seed);
            sendInstr(rnd[15:0], rnd[20:16]);
        end
        idleCycle();

        // let the last strobes drain
        guard = 0;
        while (checkCount < sentCount && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (checkCount < sentCount) begin
            errorCount++;
            $display("timeout: %0d strobes sent but only %0d outputs seen", sentCount,
                     checkCount);
        end
        $display("strobes %0d, checked %0d, errors %0d", sentCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/decoderTop.sv */
// decoder top: combinational decode path feeding the one-cycle stage register
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

module decoderTop
    import decoderPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  instrValid,
    input  logic [`WORD_W-1:0]    instruction,
    input  logic [`FLAG_W-1:0]    psr,
    output logic                  outValid,
    output logic                  regWriteEn,
    output logic                  ramWriteEn,
    output logic                  pcWrite,
    output logic                  immSelect,
    output immType_t              immType,
    output logic                  pcOrRegSelect,
    output logic                  aluWriteBack,
    output logic [`REG_IDX_W-1:0] regWriteAddr,
    output logic [`REG_IDX_W-1:0] linkReg,
    output logic [`WORD_W-1:0]    instructionOut
);

    instrWord_t         instrWord;
    logic               taken;
    rewrite_t           rewriteKind;
    logic [`WORD_W-1:0] rewritten;

    ctrlBus ctrlIf ();

    assign instrWord = instruction;

    // condition code sits in the dest field
    condEval u_condEval (
        .cond  (cond_t'(instrWord.rForm.dest)),
        .psr   (psr),
        .taken (taken)
    );

    controlGen u_controlGen (
        .instr       (instrWord),
        .taken       (taken),
        .ctrl        (ctrlIf.gen),
        .rewriteKind (rewriteKind)
    );

    instrRewrite u_instrRewrite (
        .instr       (instrWord),
        .rewriteKind (rewriteKind),
        .rewritten   (rewritten)
    );

    decodeStage u_decodeStage (
        .clk            (clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .ctrl           (ctrlIf.stage),
        .rewritten      (rewritten),
        .outValid       (outValid),
        .regWriteEn     (regWriteEn),
        .ramWriteEn     (ramWriteEn),
        .pcWrite        (pcWrite),
        .immSelect      (immSelect),
        .immType        (immType),
        .pcOrRegSelect  (pcOrRegSelect),
        .aluWriteBack   (aluWriteBack),
        .regWriteAddr   (regWriteAddr),
        .linkReg        (linkReg),
        .instructionOut (instructionOut)
    );

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
// decode stage register: captures controls and rewritten word on the valid strobe
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

module decodeStage
    import decoderPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  instrValid,
    ctrlBus.stage                 ctrl,
    input  logic [`WORD_W-1:0]    rewritten,
    output logic                  outValid,
    output logic                  regWriteEn,
    output logic                  ramWriteEn,
    output logic                  pcWrite,
    output logic                  immSelect,
    output immType_t              immType,
    output logic                  pcOrRegSelect,
    output logic                  aluWriteBack,
    output logic [`REG_IDX_W-1:0] regWriteAddr,
    output logic [`REG_IDX_W-1:0] linkReg,
    output logic [`WORD_W-1:0]    instructionOut
);

    // valid, enables and word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid       <= 1'b0;
            regWriteEn     <= 1'b0;
            ramWriteEn     <= 1'b0;
            pcWrite        <= 1'b0;
            instructionOut <= '0;
        end else begin
            outValid   <= instrValid;
            // enables only live for one cycle per strobe
            regWriteEn <= instrValid && ctrl.regWriteEn;
            ramWriteEn <= instrValid && ctrl.ramWriteEn;
            pcWrite    <= instrValid && ctrl.pcWrite;
            if (instrValid) begin
                instructionOut <= rewritten;
            end
        end
    end

    // selects and indices hold between strobes
    always_ff @(posedge clk) begin
        if (instrValid) begin
            immSelect     <= ctrl.immSelect;
            immType       <= ctrl.immType;
            pcOrRegSelect <= ctrl.pcOrRegSelect;
            aluWriteBack  <= ctrl.aluWriteBack;
            regWriteAddr  <= ctrl.regWriteAddr;
            linkReg       <= ctrl.linkReg;
        end
    end

endmodule

`default_nettype wire

/* rtl/instrRewrite.sv */
// instruction rewrite: builds the word the alu sees for each rewrite kind
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

module instrRewrite
    import decoderPkg::*;
(
    input  instrWord_t         instr,
    input  rewrite_t           rewriteKind,
    output logic [`WORD_W-1:0] rewritten
);

    always_comb begin
        case (rewriteKind)
            rwNop: begin
                rewritten = `NOP_WORD;
            end
            // address = dest + src through an ADDU
            rwLoad: begin
                rewritten = {`OP_RTYPE, instr.rForm.dest, `ADDU_EXT, instr.rForm.src};
            end
            // fields swapped, address register moves to src
            rwStore: begin
                rewritten = {`OP_RTYPE, instr.rForm.src, `ADDU_EXT, instr.rForm.dest};
            end
            // target register plus r0
            rwJal, rwJump: begin
                rewritten = {`OP_RTYPE, 4'b0000, `ADDU_EXT, instr.rForm.src};
            end
            rwBranch: begin
                rewritten = {`BRANCH_PREFIX, instr.iForm.imm};
            end
            default: begin
                rewritten = instr;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/controlGen.sv */
// control generation: opcode decode into datapath controls and a rewrite kind
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

module controlGen
    import decoderPkg::*;
(
    input  instrWord_t instr,
    input  logic       taken,
    ctrlBus.gen        ctrl,
    output rewrite_t   rewriteKind
);

    always_comb begin
        // quiet defaults, reg1 and reg2 into the alu
        ctrl.regWriteEn    = 1'b0;
        ctrl.ramWriteEn    = 1'b0;
        ctrl.pcWrite       = 1'b0;
        ctrl.immSelect     = 1'b0;
        ctrl.immType       = immRaw;
        ctrl.pcOrRegSelect = 1'b1;
        ctrl.aluWriteBack  = 1'b1;
        ctrl.regWriteAddr  = instr.rForm.dest;
        ctrl.linkReg       = '0;
        rewriteKind        = rwKeep;

        case (instr.rForm.opcode)
            `OP_RTYPE: begin
                // compare only updates psr
                ctrl.regWriteEn = (instr.rForm.ext != `EXT_CMP);
            end
            `OP_SHIFT: begin
                ctrl.regWriteEn = 1'b1;
                // anything but LSH is the immediate shift
                if (instr.rForm.ext != `EXT_LSH) begin
                    ctrl.immSelect = 1'b1;
                    ctrl.immType   = immRaw;
                end
            end
            `OP_ADDI, `OP_ADDUI, `OP_SUBI: begin
                ctrl.regWriteEn = 1'b1;
                ctrl.immSelect  = 1'b1;
                ctrl.immType    = immSign;
            end
            `OP_CMPI: begin
                // psr only, no write
                ctrl.immSelect = 1'b1;
                ctrl.immType   = immSign;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_MOVI: begin
                ctrl.regWriteEn = 1'b1;
                ctrl.immSelect  = 1'b1;
                ctrl.immType    = immZero;
            end
            `OP_LUI: begin
                ctrl.regWriteEn = 1'b1;
                ctrl.immSelect  = 1'b1;
                ctrl.immType    = immRaw;
            end
            `OP_MEMJMP: begin
                case (instr.rForm.ext)
                    `EXT_LOAD: begin
                        // address passes the alu, ram data written back
                        ctrl.regWriteEn   = 1'b1;
                        ctrl.immSelect    = 1'b1;
                        ctrl.immType      = immNone;
                        ctrl.aluWriteBack = 1'b0;
                        rewriteKind       = rwLoad;
                    end
                    `EXT_STORE: begin
                        ctrl.ramWriteEn = 1'b1;
                        rewriteKind     = rwStore;
                    end
                    `EXT_JAL: begin
                        // return address goes to the link register
                        ctrl.pcWrite   = 1'b1;
                        ctrl.immSelect = 1'b1;
                        ctrl.immType   = immNone;
                        ctrl.linkReg   = instr.rForm.dest;
                        rewriteKind    = rwJal;
                    end
                    `EXT_JCOND: begin
                        if (taken) begin
                            ctrl.pcWrite   = 1'b1;
                            ctrl.immSelect = 1'b1;
                            ctrl.immType   = immNone;
                            rewriteKind    = rwJump;
                        end else begin
                            rewriteKind = rwNop;
                        end
                    end
                    default: begin
                        rewriteKind = rwKeep;
                    end
                endcase
            end
            `OP_BCOND: begin
                // pc plus signed displacement
                if (taken) begin
                    ctrl.pcWrite       = 1'b1;
                    ctrl.immSelect     = 1'b1;
                    ctrl.immType       = immSign;
                    ctrl.pcOrRegSelect = 1'b0;
                    rewriteKind        = rwBranch;
                end else begin
                    rewriteKind = rwNop;
                end
            end
            default: begin
                rewriteKind = rwKeep;
            end
        endcase

        // all-zero word already decodes as an r0 write, same as NOP
        if (instr == '0) begin
            rewriteKind = rwNop;
        end
    end

endmodule

`default_nettype wire

/* rtl/condEval.sv */
// condition evaluator: decides whether a jump or branch is taken from the psr flags
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

module condEval
    import decoderPkg::*;
(
    input  cond_t              cond,
    input  logic [`FLAG_W-1:0] psr,
    output logic               taken
);

    logic neg;
    logic zer;
    logic flg;
    logic low;
    logic car;

    // name the flags once
    assign neg = psr[psrNegative];
    assign zer = psr[psrZero];
    assign flg = psr[psrFlag];
    assign low = psr[psrLow];
    assign car = psr[psrCarry];

    // one rule per code, shared by JCond and Bcond
    always_comb begin
        case (cond)
            Eq:            taken = zer;
            Neq:           taken = !zer;
            // signed compares
            GreaterThan:   taken = neg;
            Geq:           taken = neg || zer;
            LessThan:      taken = !neg && !zer;
            Leq:           taken = !neg;
            CarrySet:      taken = car;
            CarryClear:    taken = !car;
            // unsigned compares use the low flag
            HigherThan:    taken = low;
            HigherOrSame:  taken = low || zer;
            LowerOrSame:   taken = !low;
            Lo:            taken = !low && !zer;
            Fset:          taken = flg;
            Fclear:        taken = !flg;
            Unconditional: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ctrlBus.sv */
// control bundle between control generation and the decode stage register
`default_nettype none
`timescale 1ns/100ps

`include "decoder_macros.svh"

interface ctrlBus
    import decoderPkg::*;
();

    // enables
    logic                  regWriteEn;
    logic                  ramWriteEn;
    logic                  pcWrite;
    // datapath mux selects
    logic                  immSelect;
    immType_t              immType;
    logic                  pcOrRegSelect;
    logic                  aluWriteBack;
    // register indices
    logic [`REG_IDX_W-1:0] regWriteAddr;
    logic [`REG_IDX_W-1:0] linkReg;

    // decode side drives
    modport gen (
        output regWriteEn, ramWriteEn, pcWrite, immSelect, immType,
        output pcOrRegSelect, aluWriteBack, regWriteAddr, linkReg
    );

    // pipeline register samples
    modport stage (
        input regWriteEn, ramWriteEn, pcWrite, immSelect, immType,
        input pcOrRegSelect, aluWriteBack, regWriteAddr, linkReg
    );

endinterface

`default_nettype wire

/* rtl/decoderPkg.sv */
// decoder types: instruction word views, immediate and condition codes, rewrite kinds
`default_nettype none

`include "decoder_macros.svh"

package decoderPkg;

    // register-register view
    typedef struct packed {
        logic [`FIELD_W-1:0] opcode;
        // also the condition code for jumps and branches
        logic [`FIELD_W-1:0] dest;
        logic [`FIELD_W-1:0] ext;
        logic [`FIELD_W-1:0] src;
    } rForm_t;

    // register-immediate view
    typedef struct packed {
        logic [`FIELD_W-1:0] opcode;
        logic [`FIELD_W-1:0] dest;
        logic [`IMM_W-1:0]   imm;
    } iForm_t;

    // same word, decoded either way
    typedef union packed {
        rForm_t rForm;
        iForm_t iForm;
    } instrWord_t;

    // how the alu extends the 8-bit immediate
    typedef enum logic [1:0] {
        immRaw  = 2'd0,
        immSign = 2'd1,
        immZero = 2'd2,
        immNone = 2'd3
    } immType_t;

    // condition codes for JCond and Bcond
    typedef enum logic [3:0] {
        Eq            = 4'b0000,
        Neq           = 4'b0001,
        CarrySet      = 4'b0010,
        CarryClear    = 4'b0011,
        HigherThan    = 4'b0100,
        LowerOrSame   = 4'b0101,
        GreaterThan   = 4'b0110,
        Leq           = 4'b0111,
        Fset          = 4'b1000,
        Fclear        = 4'b1001,
        Lo            = 4'b1010,
        HigherOrSame  = 4'b1011,
        LessThan      = 4'b1100,
        Geq           = 4'b1101,
        Unconditional = 4'b1110,
        NoJump        = 4'b1111
    } cond_t;

    // bit positions inside psr
    typedef enum logic [2:0] {
        psrCarry    = 3'd0,
        psrLow      = 3'd1,
        psrFlag     = 3'd2,
        psrZero     = 3'd3,
        psrNegative = 3'd4
    } flagIdx_t;

    // what the outgoing word becomes
    typedef enum logic [2:0] {
        rwKeep,
        rwNop,
        rwLoad,
        rwStore,
        rwJal,
        rwJump,
        rwBranch
    } rewrite_t;

endpackage

`default_nettype wire

/* rtl/decoder_macros.svh */
// decoder constants: word widths, opcode and extension encodings, fixed rewrite words
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

// widths
`define WORD_W        16
`define REG_IDX_W     4
`define FLAG_W        5
`define FIELD_W       4
`define IMM_W         8

// fixed words used by the rewrite
// or r0,r0 does nothing
`define NOP_WORD      16'h0020
`define ADDU_EXT      4'b0110
`define BRANCH_PREFIX 8'h50

// primary opcodes
`define OP_RTYPE      4'b0000
`define OP_ANDI       4'b0001
`define OP_ORI        4'b0010
`define OP_XORI       4'b0011
`define OP_MEMJMP     4'b0100
`define OP_ADDI       4'b0101
`define OP_ADDUI      4'b0110
`define OP_SHIFT      4'b1000
`define OP_SUBI       4'b1001
`define OP_CMPI       4'b1011
`define OP_BCOND      4'b1100
`define OP_MOVI       4'b1101
`define OP_LUI        4'b1111

// extension codes
`define EXT_CMP       4'b1011
`define EXT_LSH       4'b0100
`define EXT_LOAD      4'b0000
`define EXT_STORE     4'b0100
`define EXT_JAL       4'b1000
`define EXT_JCOND     4'b1100

`endif
